// File: common/ads868x_pkg.sv
// Converter, SPI frame and sample constants with the channel and sample types

package ads868x_pkg;

    // ==========================================================================
    // Converter and output stream
    // ==========================================================================
    localparam int sample_width = 16;
    // Signed Q1.15
    localparam int coe_width    = 16;
    localparam int out_width    = 32;

    // Analog mux
    localparam int max_channels = 8;
    localparam int chan_width   = 3;

    // ==========================================================================
    // SPI frame and timing, in aclk cycles
    // ==========================================================================
    localparam int frame_bytes     = 4;
    localparam int sck_half_period = 4;
    // Wait after each mux change
    localparam int settle_cycles   = 16;

    typedef logic [chan_width-1:0]   chan_t;
    typedef logic [sample_width-1:0] sample_t;

endpackage

// File: common/ads868x_regs_pkg.sv
// Register bus width, register map, reset values and identification word

package ads868x_regs_pkg;

    // Word addresses
    localparam int up_addr_width = 10;

    // ==========================================================================
    // Register map
    // ==========================================================================
    localparam logic [up_addr_width-1:0] addr_id           = 10'd0;
    localparam logic [up_addr_width-1:0] addr_ctrl         = 10'd1;
    localparam logic [up_addr_width-1:0] addr_mux_en       = 10'd2;
    localparam logic [up_addr_width-1:0] addr_coe          = 10'd3;
    localparam logic [up_addr_width-1:0] addr_chan_count   = 10'd4;
    localparam logic [up_addr_width-1:0] addr_sample_count = 10'd5;

    // Reset values
    localparam logic [31:0] id_value         = 32'h0868_0001;
    localparam logic [15:0] coe_reset        = 16'h7fff;
    localparam logic [3:0]  chan_count_reset = 4'd8;

endpackage

// File: common/spi_byte_if.sv
// Byte stream interface between the scan controller and the SPI master
`timescale 1ns/1ps

interface spi_byte_if;

    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic [7:0] rx_data;
    logic       rx_valid;
    // Chip select held low while set
    logic       frame;

    modport controller (
        output tx_data, tx_valid, frame,
        input  tx_ready, rx_data, rx_valid
    );

    modport master (
        input  tx_data, tx_valid, frame,
        output tx_ready, rx_data, rx_valid
    );

endinterface

// File: ads868x/ads868x_regs.sv
// Register file on the req/ack bus with control, mux, coefficient and sample count
`timescale 1ns/1ps

module ads868x_regs (
    input  logic                                       aclk,
    input  logic                                       reset,
    input  logic                                       up_wr_req,
    input  logic [ads868x_regs_pkg::up_addr_width-1:0] up_wr_addr,
    input  logic [3:0]                                 up_wr_be,
    input  logic [31:0]                                up_wr_data,
    output logic                                       up_wr_ack,
    input  logic                                       up_rd_req,
    input  logic [ads868x_regs_pkg::up_addr_width-1:0] up_rd_addr,
    output logic [31:0]                                up_rd_data,
    output logic                                       up_rd_ack,
    input  logic                                       m_tvalid,
    input  logic                                       m_tready,
    output logic                                       enable,
    output logic                                       soft_reset,
    output logic                                       rst_pd_n,
    output logic [3:0]                                 mux_en,
    output logic signed [ads868x_pkg::coe_width-1:0]   coe,
    output logic [3:0]                                 chan_count
);
    import ads868x_pkg::*;
    import ads868x_regs_pkg::*;

    logic [31:0] sample_count;
    logic [3:0]  count_clamped;

    // Zero or out of range count selects all channels
    always_comb begin
        if (up_wr_data[7:0] == 8'd0 || up_wr_data[7:0] > 8'(max_channels))
            count_clamped = 4'(max_channels);
        else
            count_clamped = up_wr_data[3:0];
    end

    // ==========================================================================
    // Writes and acks
    // ==========================================================================
    always_ff @(posedge aclk) begin
        if (reset) begin
            up_wr_ack  <= 1'b0;
            up_rd_ack  <= 1'b0;
            soft_reset <= 1'b0;
            enable     <= 1'b0;
            rst_pd_n   <= 1'b0;
            mux_en     <= '0;
            coe        <= coe_reset;
            chan_count <= chan_count_reset;
        end else begin
            up_wr_ack  <= up_wr_req;
            up_rd_ack  <= up_rd_req;
            soft_reset <= 1'b0;
            if (up_wr_req && up_wr_be[0]) begin
                case (up_wr_addr)
                    addr_ctrl: begin
                        // Bit 0 self-clears
                        soft_reset <= up_wr_data[0];
                        enable     <= up_wr_data[1];
                        rst_pd_n   <= up_wr_data[2];
                    end
                    addr_mux_en:     mux_en     <= up_wr_data[3:0];
                    addr_coe:        coe[7:0]   <= up_wr_data[7:0];
                    addr_chan_count: chan_count <= count_clamped;
                    default: ;
                endcase
            end
            if (up_wr_req && up_wr_be[1] && up_wr_addr == addr_coe)
                coe[15:8] <= up_wr_data[15:8];
        end
    end

    // Output handshakes since reset or soft reset
    always_ff @(posedge aclk) begin
        if (reset || soft_reset)
            sample_count <= '0;
        else if (m_tvalid && m_tready)
            sample_count <= sample_count + 32'd1;
    end

    // ==========================================================================
    // Reads
    // ==========================================================================
    always_ff @(posedge aclk) begin
        if (up_rd_req) begin
            case (up_rd_addr)
                addr_id:           up_rd_data <= id_value;
                addr_ctrl:         up_rd_data <= {29'd0, rst_pd_n, enable, 1'b0};
                addr_mux_en:       up_rd_data <= {28'd0, mux_en};
                addr_coe:          up_rd_data <= {16'd0, coe};
                addr_chan_count:   up_rd_data <= {28'd0, chan_count};
                addr_sample_count: up_rd_data <= sample_count;
                default:           up_rd_data <= '0;
            endcase
        end
    end

endmodule

// File: ads868x/ads868x_conv_ctrl.sv
// Scan sequencer for mux select, settling, SPI frames and sample hand-off
`timescale 1ns/1ps

module ads868x_conv_ctrl (
    input  logic                 aclk,
    input  logic                 reset,
    input  logic                 soft_reset,
    input  logic                 enable,
    input  logic                 pps,
    input  logic [3:0]           chan_count,
    spi_byte_if.controller       spi,
    output ads868x_pkg::sample_t sample,
    output ads868x_pkg::chan_t   chan,
    output logic                 valid,
    input  logic                 ready,
    output logic [2:0]           ch_sel
);
    import ads868x_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_settle,
        st_xfer,
        st_offer
    } state_t;

    state_t                             state;
    logic                               pps_d;
    logic                               pps_rise;
    logic                               last_chan;
    logic [$clog2(settle_cycles+1)-1:0] settle_cnt;
    logic [2:0]                         tx_cnt;
    logic [1:0]                         rx_cnt;

    assign pps_rise  = pps && !pps_d;
    assign last_chan = ({1'b0, chan} + 4'd1) == chan_count;
    assign ch_sel    = chan;
    assign valid     = (state == st_offer);

    // Command bytes are all zero
    assign spi.tx_data  = 8'h00;
    assign spi.tx_valid = (state == st_xfer) && (tx_cnt != 3'(frame_bytes));

    always_ff @(posedge aclk) begin
        if (reset)
            pps_d <= 1'b0;
        else
            pps_d <= pps;
    end

    // ==========================================================================
    // Scan FSM
    // ==========================================================================
    always_ff @(posedge aclk) begin
        if (reset || soft_reset) begin
            state      <= st_idle;
            chan       <= '0;
            settle_cnt <= '0;
            tx_cnt     <= '0;
            rx_cnt     <= '0;
            spi.frame  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // pps during a scan is ignored here
                    if (pps_rise && enable) begin
                        chan       <= '0;
                        settle_cnt <= ($bits(settle_cnt))'(settle_cycles - 1);
                        state      <= st_settle;
                    end
                end
                st_settle: begin
                    if (settle_cnt == '0) begin
                        spi.frame <= 1'b1;
                        tx_cnt    <= '0;
                        rx_cnt    <= '0;
                        state     <= st_xfer;
                    end else begin
                        settle_cnt <= settle_cnt - 1'b1;
                    end
                end
                st_xfer: begin
                    if (spi.tx_valid && spi.tx_ready)
                        tx_cnt <= tx_cnt + 3'd1;
                    if (spi.rx_valid) begin
                        rx_cnt <= rx_cnt + 2'd1;
                        if (rx_cnt == 2'(frame_bytes - 1)) begin
                            spi.frame <= 1'b0;
                            state     <= st_offer;
                        end
                    end
                end
                st_offer: begin
                    // Next channel only once the scaler took this one
                    if (ready) begin
                        if (last_chan) begin
                            state <= st_idle;
                        end else begin
                            chan       <= chan + 1'b1;
                            settle_cnt <= ($bits(settle_cnt))'(settle_cycles - 1);
                            state      <= st_settle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Result sits in the first two bytes, MSB first
    always_ff @(posedge aclk) begin
        if (state == st_xfer && spi.rx_valid && rx_cnt < 2'd2)
            sample <= {sample[7:0], spi.rx_data};
    end

endmodule

// File: ads868x/ads868x_scale.sv
// Two-stage signed Q1.15 scaling pipeline with valid/ready flow control
`timescale 1ns/1ps

module ads868x_scale (
    input  logic                                     aclk,
    input  logic                                     reset,
    input  logic                                     soft_reset,
    input  logic signed [ads868x_pkg::coe_width-1:0] coe,
    input  ads868x_pkg::sample_t                     s_sample,
    input  ads868x_pkg::chan_t                       s_chan,
    input  logic                                     s_valid,
    output logic                                     s_ready,
    output logic [ads868x_pkg::out_width-1:0]        m_data,
    output ads868x_pkg::chan_t                       m_chan,
    output logic                                     m_valid,
    input  logic                                     m_ready
);
    import ads868x_pkg::*;

    logic signed [sample_width-1:0] s1_sample;
    logic signed [coe_width-1:0]    s1_coe;
    chan_t                          s1_chan;
    logic                           s1_valid;
    logic                           s1_adv;
    logic                           s2_adv;
    logic signed [out_width-1:0]    product;

    // Each stage moves when the one after it is empty or draining
    assign s2_adv  = !m_valid || m_ready;
    assign s1_adv  = !s1_valid || s2_adv;
    assign s_ready = s1_adv;
    assign product = s1_sample * s1_coe;

    always_ff @(posedge aclk) begin
        if (reset || soft_reset) begin
            s1_valid <= 1'b0;
            m_valid  <= 1'b0;
        end else begin
            if (s1_adv)
                s1_valid <= s_valid;
            if (s2_adv)
                m_valid <= s1_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (s1_adv) begin
            s1_sample <= s_sample;
            s1_coe    <= coe;
            s1_chan   <= s_chan;
        end
        if (s2_adv) begin
            m_data <= product;
            m_chan <= s1_chan;
        end
    end

endmodule

// File: verilog/spi_master.sv
// Mode 0 byte-wide SPI master with SCK divided from aclk
`timescale 1ns/1ps

module spi_master #(
    parameter int half_period = ads868x_pkg::sck_half_period
) (
    input  logic        aclk,
    input  logic        reset,
    input  logic        soft_reset,
    spi_byte_if.master  spi,
    output logic        sck,
    output logic        cs_n,
    output logic        mosi,
    input  logic        miso
);

    logic                               busy;
    logic                               edge_tick;
    logic [$clog2(half_period+1)-1:0]   div_cnt;
    logic [2:0]                         bit_cnt;
    logic [7:0]                         tx_shift;
    logic [7:0]                         rx_shift;

    // One SCK edge per half period while a byte shifts
    assign edge_tick    = busy && (div_cnt == ($bits(div_cnt))'(half_period - 1));
    assign spi.tx_ready = spi.frame && !busy;
    assign spi.rx_data  = rx_shift;
    assign mosi         = tx_shift[7];

    // ==========================================================================
    // Byte shifter
    // ==========================================================================
    always_ff @(posedge aclk) begin
        if (reset || soft_reset) begin
            busy         <= 1'b0;
            sck          <= 1'b0;
            cs_n         <= 1'b1;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            tx_shift     <= '0;
            spi.rx_valid <= 1'b0;
        end else begin
            cs_n         <= !spi.frame;
            spi.rx_valid <= 1'b0;
            if (spi.tx_valid && spi.tx_ready) begin
                // MSB goes out before the first rising edge
                busy     <= 1'b1;
                tx_shift <= spi.tx_data;
                div_cnt  <= '0;
                bit_cnt  <= '0;
            end else if (busy) begin
                if (edge_tick) begin
                    div_cnt <= '0;
                    sck     <= !sck;
                    // Falling edge
                    if (sck) begin
                        if (bit_cnt == 3'd7) begin
                            busy         <= 1'b0;
                            spi.rx_valid <= 1'b1;
                        end else begin
                            bit_cnt  <= bit_cnt + 3'd1;
                            tx_shift <= {tx_shift[6:0], 1'b0};
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    // MISO sampled on the rising edge
    always_ff @(posedge aclk) begin
        if (edge_tick && !sck)
            rx_shift <= {rx_shift[6:0], miso};
    end

endmodule

// File: verilog/ads868x_top.sv
// Top level joining the register file, scan controller, scaler and SPI master
`timescale 1ns/1ps

module ads868x_top (
    input  logic                                       aclk,
    input  logic                                       reset,
    input  logic                                       pps,
    input  logic                                       up_wr_req,
    input  logic [ads868x_regs_pkg::up_addr_width-1:0] up_wr_addr,
    input  logic [3:0]                                 up_wr_be,
    input  logic [31:0]                                up_wr_data,
    output logic                                       up_wr_ack,
    input  logic                                       up_rd_req,
    input  logic [ads868x_regs_pkg::up_addr_width-1:0] up_rd_addr,
    output logic [31:0]                                up_rd_data,
    output logic                                       up_rd_ack,
    output logic [ads868x_pkg::out_width-1:0]          m_tdata,
    output ads868x_pkg::chan_t                         m_tchan,
    output logic                                       m_tvalid,
    input  logic                                       m_tready,
    output logic                                       sck,
    output logic                                       cs_n,
    output logic                                       mosi,
    input  logic                                       miso,
    output logic                                       rst_pd_n,
    output logic                                       ch_sel_a0,
    output logic                                       ch_sel_a1,
    output logic                                       ch_sel_a2,
    output logic                                       en_tch_a,
    output logic                                       en_pch_a,
    output logic                                       en_tch_b,
    output logic                                       en_pch_b
);
    import ads868x_pkg::*;

    logic                        enable;
    logic                        soft_reset;
    logic [3:0]                  mux_en;
    logic signed [coe_width-1:0] coe;
    logic [3:0]                  chan_count;
    sample_t                     adc_sample;
    chan_t                       adc_chan;
    logic                        adc_valid;
    logic                        adc_ready;
    logic [2:0]                  ch_sel;

    spi_byte_if spi_bus ();

    ads868x_regs i_regs (
        .aclk       (aclk),
        .reset      (reset),
        .up_wr_req  (up_wr_req),
        .up_wr_addr (up_wr_addr),
        .up_wr_be   (up_wr_be),
        .up_wr_data (up_wr_data),
        .up_wr_ack  (up_wr_ack),
        .up_rd_req  (up_rd_req),
        .up_rd_addr (up_rd_addr),
        .up_rd_data (up_rd_data),
        .up_rd_ack  (up_rd_ack),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .enable     (enable),
        .soft_reset (soft_reset),
        .rst_pd_n   (rst_pd_n),
        .mux_en     (mux_en),
        .coe        (coe),
        .chan_count (chan_count)
    );

    ads868x_conv_ctrl i_ctrl (
        .aclk       (aclk),
        .reset      (reset),
        .soft_reset (soft_reset),
        .enable     (enable),
        .pps        (pps),
        .chan_count (chan_count),
        .spi        (spi_bus.controller),
        .sample     (adc_sample),
        .chan       (adc_chan),
        .valid      (adc_valid),
        .ready      (adc_ready),
        .ch_sel     (ch_sel)
    );

    ads868x_scale i_scale (
        .aclk       (aclk),
        .reset      (reset),
        .soft_reset (soft_reset),
        .coe        (coe),
        .s_sample   (adc_sample),
        .s_chan     (adc_chan),
        .s_valid    (adc_valid),
        .s_ready    (adc_ready),
        .m_data     (m_tdata),
        .m_chan     (m_tchan),
        .m_valid    (m_tvalid),
        .m_ready    (m_tready)
    );

    spi_master i_spi (
        .aclk       (aclk),
        .reset      (reset),
        .soft_reset (soft_reset),
        .spi        (spi_bus.master),
        .sck        (sck),
        .cs_n       (cs_n),
        .mosi       (mosi),
        .miso       (miso)
    );

    // Mux pins
    assign {ch_sel_a2, ch_sel_a1, ch_sel_a0}           = ch_sel;
    assign {en_pch_b, en_tch_b, en_pch_a, en_tch_a}    = mux_en;

endmodule

// File: verification/ads868x_sva.sv
// Concurrent assertions on the stream, SPI and register bus ports of the top level
`timescale 1ns/1ps

module ads868x_sva (
    input logic                              aclk,
    input logic                              reset,
    input logic                              m_tvalid,
    input logic                              m_tready,
    input logic [ads868x_pkg::out_width-1:0] m_tdata,
    input ads868x_pkg::chan_t                m_tchan,
    input logic                              sck,
    input logic                              cs_n,
    input logic                              up_wr_req,
    input logic                              up_wr_ack,
    input logic                              up_rd_req,
    input logic                              up_rd_ack
);
    int fail_count = 0;

    // Stalled output holds its payload
    stream_stable: assert property (@(posedge aclk) disable iff (reset)
        m_tvalid && !m_tready |=> $stable(m_tdata) && $stable(m_tchan))
        else begin
            $error("m_tdata or m_tchan changed while stalled");
            fail_count++;
        end

    sck_idle_low: assert property (@(posedge aclk) disable iff (reset) cs_n |-> !sck)
        else begin
            $error("sck high while cs_n is high");
            fail_count++;
        end

    // Acks trail their requests by exactly one cycle
    wr_ack_timing: assert property (@(posedge aclk) disable iff (reset)
        up_wr_ack == $past(up_wr_req))
        else begin
            $error("up_wr_ack not one cycle after up_wr_req");
            fail_count++;
        end

    rd_ack_timing: assert property (@(posedge aclk) disable iff (reset)
        up_rd_ack == $past(up_rd_req))
        else begin
            $error("up_rd_ack not one cycle after up_rd_req");
            fail_count++;
        end

endmodule

bind ads868x_top ads868x_sva sva_i (.*);

// File: verification/tb_ads868x.sv
// Testbench with clock, reset, xorshift stimulus, ADC slave model, bus tasks and checks
`timescale 1ns/1ps

module tb_ads868x;
    import ads868x_pkg::*;
    import ads868x_regs_pkg::*;

    localparam int ack_timeout  = 8;
    localparam int scan_timeout = 40000;
    localparam int quiet_cycles = 400;

    logic                     aclk = 1'b0;
    logic                     reset = 1'b1;
    logic                     pps = 1'b0;
    logic                     up_wr_req = 1'b0;
    logic [up_addr_width-1:0] up_wr_addr = '0;
    logic [3:0]               up_wr_be = '0;
    logic [31:0]              up_wr_data = '0;
    logic                     up_wr_ack;
    logic                     up_rd_req = 1'b0;
    logic [up_addr_width-1:0] up_rd_addr = '0;
    logic [31:0]              up_rd_data;
    logic                     up_rd_ack;
    logic [out_width-1:0]     m_tdata;
    chan_t                    m_tchan;
    logic                     m_tvalid;
    logic                     m_tready = 1'b1;
    logic                     sck;
    logic                     cs_n;
    logic                     mosi;
    logic                     miso = 1'b0;
    logic                     rst_pd_n;
    logic                     ch_sel_a0;
    logic                     ch_sel_a1;
    logic                     ch_sel_a2;
    logic                     en_tch_a;
    logic                     en_pch_a;
    logic                     en_tch_b;
    logic                     en_pch_b;

    // Model state
    logic [31:0] rng = 32'hcd0;
    // Separate stream for the ADC model and ready
    logic [31:0] bus_rng = ~32'hcd0;
    logic [18:0] expected[$];
    logic [31:0] miso_shift = '0;
    logic        cs_d = 1'b1;
    logic        sck_d = 1'b0;
    logic        rand_ready = 1'b0;
    int          rx_idx = 0;
    int          hs_total = 0;
    logic [3:0]  mux_val = '0;
    logic [15:0] coe_val = coe_reset;
    logic [3:0]  count_val = chan_count_reset;

    ads868x_top DUT (.*);

    always #50 aclk = ~aclk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Q1.15 coefficient times raw sample, full 32 bit result
    function automatic logic [31:0] scaled(input logic [15:0] value, input logic [15:0] c);
        int a;
        int b;
        a = $signed(value);
        b = $signed(c);
        return a * b;
    endfunction

    function automatic logic [3:0] clamp_count(input logic [7:0] v);
        if (v == 8'd0 || v > 8'(max_channels))
            return 4'(max_channels);
        return v[3:0];
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_stop("Value check failed");
        end
    endtask

    // ==========================================================================
    // Register bus
    // ==========================================================================
    task automatic write_reg(input logic [9:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        int waited;
        waited = 0;
        up_wr_req  = 1'b1;
        up_wr_addr = addr;
        up_wr_be   = be;
        up_wr_data = data;
        @(negedge aclk);
        up_wr_req = 1'b0;
        while (!up_wr_ack && waited < ack_timeout) begin
            @(negedge aclk);
            waited++;
        end
        if (!up_wr_ack)
            fail_stop("Register write was never acknowledged");
    endtask

    task automatic read_reg(input logic [9:0] addr, output logic [31:0] data);
        int waited;
        waited = 0;
        up_rd_req  = 1'b1;
        up_rd_addr = addr;
        @(negedge aclk);
        up_rd_req = 1'b0;
        while (!up_rd_ack && waited < ack_timeout) begin
            @(negedge aclk);
            waited++;
        end
        data = up_rd_data;
        if (!up_rd_ack)
            fail_stop("Register read was never acknowledged");
    endtask

    task automatic expect_reg(input string name, input logic [9:0] addr,
                              input logic [31:0] exp);
        logic [31:0] data;
        read_reg(addr, data);
        check(name, data, exp);
    endtask

    task automatic pulse_pps();
        pps = 1'b1;
        @(negedge aclk);
        pps = 1'b0;
    endtask

    task automatic run_scan(input int n);
        int waited;
        waited = 0;
        rx_idx = 0;
        pulse_pps();
        while (rx_idx < n && waited < scan_timeout) begin
            @(negedge aclk);
            waited++;
        end
        if (rx_idx < n) begin
            fail_stop("Timeout waiting for the scan to deliver its samples");
        end else begin
            // Nothing more may arrive after the last channel
            for (int i = 0; i < quiet_cycles; i++)
                @(negedge aclk);
            check("samples_per_scan", rx_idx, n);
            check("pending_frames", expected.size(), 0);
        end
    endtask

    // ==========================================================================
    // ADC slave model, ready generator and output monitor
    // ==========================================================================
    always @(negedge aclk) begin
        logic [15:0] value;
        logic [18:0] entry;
        if (cs_d && !cs_n) begin
            bus_rng = xorshift(bus_rng);
            value = bus_rng[15:0];
            expected.push_back({ch_sel_a2, ch_sel_a1, ch_sel_a0, value});
            miso_shift = {value, 16'h0000};
            miso = miso_shift[31];
        end else if (sck_d && !sck) begin
            miso_shift = {miso_shift[30:0], 1'b0};
            miso = miso_shift[31];
        end
        // Command bytes are all zero
        if (!cs_n && sck && !sck_d)
            check("mosi", mosi, 1'b0);
        cs_d  = cs_n;
        sck_d = sck;

        if (rand_ready) begin
            bus_rng = xorshift(bus_rng);
            m_tready = bus_rng[8];
        end else begin
            m_tready = 1'b1;
        end

        // Handshake completes on the coming rising edge
        if (!reset && m_tvalid === 1'b1 && m_tready) begin
            if (expected.size() == 0) begin
                fail_stop("Output sample arrived without an ADC frame");
            end else begin
                entry = expected.pop_front();
                check("m_tchan", m_tchan, rx_idx);
                check("m_tchan_vs_ch_sel", m_tchan, entry[18:16]);
                check("m_tdata", m_tdata, scaled(entry[15:0], coe_val));
                rx_idx++;
                hs_total++;
            end
        end

        if (DUT.sva_i.fail_count != 0)
            fail_stop("A bound assertion failed");
    end

    // ==========================================================================
    // Test sequence
    // ==========================================================================
    initial begin
        logic [31:0] data;
        logic [3:0]  be;
        logic [9:0]  addr;
        repeat (8) @(negedge aclk);
        reset = 1'b0;

        expect_reg("id", addr_id, id_value);
        expect_reg("ctrl", addr_ctrl, 32'h0);
        expect_reg("mux_en", addr_mux_en, 32'h0);
        expect_reg("coe", addr_coe, {16'h0, coe_reset});
        expect_reg("chan_count", addr_chan_count, {28'h0, chan_count_reset});
        expect_reg("sample_count", addr_sample_count, 32'h0);
        expect_reg("unmapped", 10'd9, 32'h0);

        // Random byte enables merge per byte
        for (int i = 0; i < 24; i++) begin
            rng = xorshift(rng);
            data = rng;
            rng = xorshift(rng);
            be = rng[3:0];
            case (rng[5:4])
                2'd0: begin
                    addr = addr_mux_en;
                    if (be[0])
                        mux_val = data[3:0];
                end
                2'd1: begin
                    addr = addr_coe;
                    if (be[0])
                        coe_val[7:0] = data[7:0];
                    if (be[1])
                        coe_val[15:8] = data[15:8];
                end
                default: begin
                    addr = addr_chan_count;
                    data[7:4] = 4'h0;
                    if (be[0])
                        count_val = clamp_count(data[7:0]);
                end
            endcase
            write_reg(addr, be, data);
            expect_reg("mux_en", addr_mux_en, {28'h0, mux_val});
            expect_reg("coe", addr_coe, {16'h0, coe_val});
            expect_reg("chan_count", addr_chan_count, {28'h0, count_val});
        end
        write_reg(addr_chan_count, 4'hf, 32'h0);
        expect_reg("chan_count_zero", addr_chan_count, 32'h8);

        // Mux enable and power-down pins
        for (int i = 0; i < 6; i++) begin
            rng = xorshift(rng);
            mux_val = rng[3:0];
            write_reg(addr_mux_en, 4'hf, {28'h0, mux_val});
            check("en_pins", {en_pch_b, en_tch_b, en_pch_a, en_tch_a}, mux_val);
        end
        write_reg(addr_ctrl, 4'hf, 32'h4);
        check("rst_pd_n", rst_pd_n, 1'b1);
        expect_reg("ctrl", addr_ctrl, 32'h4);
        write_reg(addr_ctrl, 4'hf, 32'h0);
        check("rst_pd_n", rst_pd_n, 1'b0);

        // Scans, the later ones under random back-pressure
        write_reg(addr_ctrl, 4'hf, 32'h6);
        for (int s = 0; s < 6; s++) begin
            rand_ready = (s >= 3);
            rng = xorshift(rng);
            coe_val = rng[15:0];
            write_reg(addr_coe, 4'hf, {16'h0, coe_val});
            rng = xorshift(rng);
            count_val = 4'(rng[2:0]) + 4'd1;
            write_reg(addr_chan_count, 4'hf, {28'h0, count_val});
            run_scan(count_val);
        end
        expect_reg("sample_count", addr_sample_count, hs_total);

        // Disabled subsystem ignores pps
        write_reg(addr_ctrl, 4'hf, 32'h4);
        pulse_pps();
        for (int i = 0; i < quiet_cycles; i++) begin
            @(negedge aclk);
            check("cs_n", cs_n, 1'b1);
        end
        check("pending_frames", expected.size(), 0);

        // Soft reset, then one more scan
        write_reg(addr_ctrl, 4'hf, 32'h7);
        // Count clears as the one-cycle soft reset pulse ends
        @(negedge aclk);
        expect_reg("sample_count", addr_sample_count, 32'h0);
        hs_total = 0;
        run_scan(count_val);
        expect_reg("sample_count", addr_sample_count, hs_total);

        if (DUT.sva_i.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_stop("Bound assertions reported failures");
        end
    end

endmodule

// File: build.f
common/ads868x_pkg.sv
common/ads868x_regs_pkg.sv
common/spi_byte_if.sv
ads868x/ads868x_regs.sv
ads868x/ads868x_conv_ctrl.sv
ads868x/ads868x_scale.sv
verilog/spi_master.sv
verilog/ads868x_top.sv
verification/ads868x_sva.sv
verification/tb_ads868x.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ads868x \
    -f build.f -o sim_ads868x
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_ads868x +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
    exit 0
else
    exit 1
fi
